//--- hdl/hc_pkg.sv
`default_nettype none

package hc_pkg;

    // Kind of read request sent toward the host
    // A header with HC_REQ_NONE never travels on a valid channel
    typedef enum logic [1:0]
    {
        HC_REQ_NONE        = 2'd0,
        HC_REQ_RDLINE      = 2'd1,
        HC_REQ_RDLINE_HINT = 2'd2
    } t_hc_req_type;

    // Read request header as it appears on the host channel
    // The tag comes back with the response so the requester can match it
    typedef struct packed
    {
        t_hc_req_type req_type;
        logic [15:0]  tag;
        logic [31:0]  line_addr;
    } t_hc_rd_hdr;

    // One requester's read port into the arbiter
    // Request stays high with a stable header until the matching grant is seen
    typedef struct packed
    {
        logic       request;
        t_hc_rd_hdr hdr;
    } t_hc_rd_req;

    // Grant vector returned to the requesters
    // At most one of the three grant bits is high in a cycle
    typedef struct packed
    {
        logic can_issue;
        logic reader_grant;
        logic writer_grant;
        logic status_grant;
    } t_hc_rd_grant;

    // Registered outgoing read channel
    typedef struct packed
    {
        logic       rd_valid;
        t_hc_rd_hdr hdr;
    } t_hc_rd_chan;

    // Software-controlled state seen by the datapath
    typedef struct packed
    {
        logic hc_en;
    } t_hc_csrs;

    // APB byte offsets of the register block
    // Bit 0 of CTRL is the channel enable
    localparam logic [7:0] HC_REG_CTRL       = 8'h00;

    // Grant counters, one per requester
    // A write of any value to one of these clears it
    localparam logic [7:0] HC_REG_CNT_READER = 8'h04;
    localparam logic [7:0] HC_REG_CNT_WRITER = 8'h08;
    localparam logic [7:0] HC_REG_CNT_STATUS = 8'h0C;

endpackage

`default_nettype wire

//--- hdl/hc_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module hc_csr_regs
#(
    parameter int CNT_WIDTH = 16
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,

    input  hc_pkg::t_hc_rd_grant rd_grant,
    output hc_pkg::t_hc_csrs     csr
);

    // Access phase of an APB transfer, the setup phase does nothing here
    logic apb_access;
    logic apb_wr;
    logic addr_ok;

    // Counter index 0 is the reader, 1 the writer, 2 the status manager
    logic [2:0]           grant_vec;
    logic [2:0]           cnt_clr;
    logic [CNT_WIDTH-1:0] grant_cnt [3];

    assign apb_access = psel && penable;
    assign apb_wr     = apb_access && pwrite;

    // No wait states, so every transfer completes in two cycles
    assign pready  = 1'b1;
    assign pslverr = apb_access && !addr_ok;

    assign grant_vec = {rd_grant.status_grant, rd_grant.writer_grant, rd_grant.reader_grant};

    // Read mux, also flags offsets that map to nothing
    always_comb
    begin
        prdata  = '0;
        addr_ok = 1'b1;
        case (paddr)
            hc_pkg::HC_REG_CTRL:       prdata = {31'b0, csr.hc_en};
            hc_pkg::HC_REG_CNT_READER: prdata = 32'(grant_cnt[0]);
            hc_pkg::HC_REG_CNT_WRITER: prdata = 32'(grant_cnt[1]);
            hc_pkg::HC_REG_CNT_STATUS: prdata = 32'(grant_cnt[2]);
            default:                   addr_ok = 1'b0;
        endcase
    end

    // Any write to a counter offset clears that counter, the data is ignored
    always_comb
    begin
        cnt_clr = '0;
        if (apb_wr)
        begin
            cnt_clr[0] = (paddr == hc_pkg::HC_REG_CNT_READER);
            cnt_clr[1] = (paddr == hc_pkg::HC_REG_CNT_WRITER);
            cnt_clr[2] = (paddr == hc_pkg::HC_REG_CNT_STATUS);
        end
    end

    // Enable bit, cleared by reset so nothing issues until software asks
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            csr.hc_en <= 1'b0;
        end
        else if (apb_wr && paddr == hc_pkg::HC_REG_CTRL)
        begin
            csr.hc_en <= pwdata[0];
        end
    end

    // Grant counters stop at all ones rather than wrapping
    // A clear in the same cycle as a grant wins
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 3; i++)
        begin
            if (!reset_n || cnt_clr[i])
            begin
                grant_cnt[i] <= '0;
            end
            else if (grant_vec[i] && grant_cnt[i] != {CNT_WIDTH{1'b1}})
            begin
                grant_cnt[i] <= grant_cnt[i] + 1'b1;
            end
        end
    end

    // The arbiter must never hand the channel to two requesters at once
    a_one_grant: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(grant_vec));

endmodule

`default_nettype wire

//--- hdl/hc_issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hc_issue_ctrl
#(
    parameter int ISSUE_SLACK = 4
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic almostfull,
    input  logic issue,
    output logic can_issue
);

    // Wide enough to hold ISSUE_SLACK itself
    localparam int                SLACK_W   = $clog2(ISSUE_SLACK + 1);
    localparam logic [SLACK_W-1:0] SLACK_MAX = SLACK_W'(ISSUE_SLACK);

    // Issues made since almostfull last rose
    logic [SLACK_W-1:0] slack_cnt;

    // The host channel still has room for a few requests after almostfull rises,
    // so issue continues until that slack is spent
    assign can_issue = !almostfull || (slack_cnt < SLACK_MAX);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            slack_cnt <= '0;
        end
        else if (!almostfull)
        begin
            // Channel has drained, full slack is available again
            slack_cnt <= '0;
        end
        else if (issue)
        begin
            slack_cnt <= slack_cnt + 1'b1;
        end
    end

    // The arbiter gates every grant with can_issue, so an issue here without it
    // would mean a request slipped past the throttle
    a_issue_allowed: assert property (@(posedge clk) disable iff (!reset_n)
        issue |-> can_issue);

endmodule

`default_nettype wire

//--- hdl/hc_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module hc_read_arbiter
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  hc_pkg::t_hc_csrs     csr,

    input  hc_pkg::t_hc_rd_req   frame_reader,
    input  hc_pkg::t_hc_rd_req   frame_writer,
    input  hc_pkg::t_hc_rd_req   status_req,

    input  logic                 can_issue,
    output hc_pkg::t_hc_rd_grant rd_grant,
    output hc_pkg::t_hc_rd_chan  tx0
);

    typedef enum logic
    {
        FAVOR_READER,
        FAVOR_WRITER
    } t_favor;

    t_favor state;
    t_favor next_state;

    // Channel has room and software has turned it on
    logic issue_ok;

    hc_pkg::t_hc_rd_hdr  header;
    logic                rd_valid;
    hc_pkg::t_hc_rd_chan tx0_upd;

    assign issue_ok = can_issue && csr.hc_en;

    // Favour the writer right after the reader won, the reader in every other case
    always_comb
    begin
        next_state = rd_grant.reader_grant ? FAVOR_WRITER : FAVOR_READER;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= FAVOR_READER;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Pick one requester, grants are combinational from this cycle's requests
    always_comb
    begin
        rd_grant              = '0;
        rd_grant.can_issue    = issue_ok;
        rd_valid              = 1'b0;
        // Reader header by default, avoids an extra mux leg
        header                = frame_reader.hdr;

        if (frame_reader.request && (state == FAVOR_READER || !frame_writer.request))
        begin
            rd_grant.reader_grant = issue_ok;
            rd_valid              = issue_ok;
        end
        else if (frame_writer.request)
        begin
            header                = frame_writer.hdr;
            rd_grant.writer_grant = issue_ok;
            rd_valid              = issue_ok;
        end
        else if (status_req.request)
        begin
            // Status only gets through when neither frame requester wants the channel
            header                = status_req.hdr;
            rd_grant.status_grant = issue_ok;
            rd_valid              = issue_ok;
        end
    end

    // An idle channel always shows req_type none
    always_comb
    begin
        tx0_upd.rd_valid = rd_valid;
        tx0_upd.hdr      = header;
        if (!rd_valid)
        begin
            tx0_upd.hdr.req_type = hc_pkg::HC_REQ_NONE;
        end
    end

    // One cycle from grant to the outgoing channel
    always_ff @(posedge clk)
    begin
        tx0.hdr <= tx0_upd.hdr;
        if (!reset_n)
        begin
            tx0.rd_valid     <= 1'b0;
            tx0.hdr.req_type <= hc_pkg::HC_REQ_NONE;
        end
        else
        begin
            tx0.rd_valid <= tx0_upd.rd_valid;
        end
    end

    // Requesters must hand in a real request kind with every request
    a_valid_type: assert property (@(posedge clk) disable iff (!reset_n)
        tx0.rd_valid |-> tx0.hdr.req_type != hc_pkg::HC_REQ_NONE);

endmodule

`default_nettype wire

//--- hdl/hc_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module hc_read_top
#(
    parameter int ISSUE_SLACK = 4,
    parameter int CNT_WIDTH   = 16
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,

    input  hc_pkg::t_hc_rd_req   frame_reader,
    input  hc_pkg::t_hc_rd_req   frame_writer,
    input  hc_pkg::t_hc_rd_req   status_req,
    output hc_pkg::t_hc_rd_grant rd_grant,

    output hc_pkg::t_hc_rd_chan  tx0,
    input  logic                 tx0_almostfull
);

    hc_pkg::t_hc_csrs csr;
    logic             can_issue;

    // Register block, also counts grants per requester
    hc_csr_regs #(
        .CNT_WIDTH (CNT_WIDTH)
    ) hc_csr_regs_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .rd_grant (rd_grant),
        .csr      (csr)
    );

    // Every grant is one issue on the host channel
    hc_issue_ctrl #(
        .ISSUE_SLACK (ISSUE_SLACK)
    ) hc_issue_ctrl_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .almostfull (tx0_almostfull),
        .issue      (rd_grant.reader_grant | rd_grant.writer_grant | rd_grant.status_grant),
        .can_issue  (can_issue)
    );

    hc_read_arbiter hc_read_arbiter_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .csr          (csr),
        .frame_reader (frame_reader),
        .frame_writer (frame_writer),
        .status_req   (status_req),
        .can_issue    (can_issue),
        .rd_grant     (rd_grant),
        .tx0          (tx0)
    );

endmodule

`default_nettype wire

//--- bench/hc_read_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hc_read_tb;

    localparam int ISSUE_SLACK = 4;
    localparam int CNT_WIDTH   = 16;

    logic                 clk;
    logic                 reset_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [7:0]           paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    hc_pkg::t_hc_rd_req   frame_reader;
    hc_pkg::t_hc_rd_req   frame_writer;
    hc_pkg::t_hc_rd_req   status_req;
    hc_pkg::t_hc_rd_grant rd_grant;
    hc_pkg::t_hc_rd_chan  tx0;
    logic                 tx0_almostfull;

    // Number of grants seen on rd_grant for each requester
    int n_reader;
    int n_writer;
    int n_status;

    hc_read_top #(
        .ISSUE_SLACK (ISSUE_SLACK),
        .CNT_WIDTH   (CNT_WIDTH)
    ) hc_read_top_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .frame_reader   (frame_reader),
        .frame_writer   (frame_writer),
        .status_req     (status_req),
        .rd_grant       (rd_grant),
        .tx0            (tx0),
        .tx0_almostfull (tx0_almostfull)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // Inputs change 1 ns after the rising edge
    // Outputs are sampled at the falling edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
        if (actual !== expected)
        begin
            $display("ERROR at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // Grant bits as {status, writer, reader}
    function automatic logic [2:0] grant_bits();
        return {rd_grant.status_grant, rd_grant.writer_grant, rd_grant.reader_grant};
    endfunction

    // Random header whose request kind is never none
    function automatic hc_pkg::t_hc_rd_hdr rand_hdr();
        hc_pkg::t_hc_rd_hdr hdr;
        hdr.req_type  = $urandom_range(1) ? hc_pkg::HC_REQ_RDLINE_HINT : hc_pkg::HC_REQ_RDLINE;
        hdr.tag       = 16'($urandom);
        hdr.line_addr = $urandom;
        return hdr;
    endfunction

    task automatic count_grants();
        if (rd_grant.reader_grant)
        begin
            n_reader++;
        end
        if (rd_grant.writer_grant)
        begin
            n_writer++;
        end
        if (rd_grant.status_grant)
        begin
            n_status++;
        end
    endtask

    // The slave has no wait states, so setup and access take one cycle each
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        @(negedge clk);
        check_eq(64'(pready), 64'd1, "pready in write access phase");
        err = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;
        @(negedge clk);
        check_eq(64'(pready), 64'd1, "pready in read access phase");
        data = prdata;
        err  = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Returns at the falling edge of the first cycle where a grant in mask is high
    task automatic wait_grant(input logic [2:0] mask, input string who);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((grant_bits() & mask) == 3'b000)
        begin
            cycles++;
            if (cycles > 50)
            begin
                $display("Timed out after %0d cycles waiting for a %s grant", cycles, who);
                $display("TEST FAILED");
                $fatal(1, "Grant timeout");
            end
            @(negedge clk);
        end
    endtask

    // A grant in one cycle shows up on tx0 in the next
    task automatic check_tx(input hc_pkg::t_hc_rd_hdr hdr);
        check_eq(64'(tx0.rd_valid), 64'd1, "tx0 valid one cycle after grant");
        check_eq(64'(tx0.hdr), 64'(hdr), "tx0 header");
    endtask

    task automatic no_grant_while_disabled();
        logic [31:0] data;
        logic        err;
        frame_reader = {1'b1, rand_hdr()};
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            check_eq(64'(grant_bits()), 64'd0, "grant while channel disabled");
            check_eq(64'(tx0.rd_valid), 64'd0, "tx0 valid while channel disabled");
            next_cycle();
        end
        frame_reader = '0;
        // CTRL and all three counters sit at consecutive word offsets
        for (int i = 0; i < 4; i++)
        begin
            apb_read(8'(i * 4), data, err);
            check_eq(64'(data), 64'd0, "register value after reset");
            check_eq(64'(err), 64'd0, "pslverr on a mapped offset");
        end
    endtask

    task automatic single_reader_grant();
        hc_pkg::t_hc_rd_hdr hdr;
        logic               err;
        apb_write(hc_pkg::HC_REG_CTRL, 32'h1, err);
        check_eq(64'(err), 64'd0, "pslverr on CTRL write");
        hdr          = rand_hdr();
        frame_reader = {1'b1, hdr};
        @(negedge clk);
        check_eq(64'(grant_bits()), 64'b001, "reader grant in its request cycle");
        check_eq(64'(rd_grant.can_issue), 64'd1, "can_issue with channel idle");
        count_grants();
        next_cycle();
        frame_reader = '0;
        @(negedge clk);
        check_tx(hdr);
        check_eq(64'(grant_bits()), 64'd0, "grant after the request dropped");
        next_cycle();
    endtask

    task automatic reader_writer_alternation();
        hc_pkg::t_hc_rd_hdr last_hdr;
        logic               reader_turn;
        frame_reader = {1'b1, rand_hdr()};
        frame_writer = {1'b1, rand_hdr()};
        status_req   = {1'b1, rand_hdr()};
        reader_turn  = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            check_eq(64'(rd_grant.reader_grant), 64'(reader_turn), "reader grant in alternation");
            check_eq(64'(rd_grant.writer_grant), 64'(!reader_turn), "writer grant in alternation");
            check_eq(64'(rd_grant.status_grant), 64'd0, "status grant while frames request");
            if (i > 0)
            begin
                check_tx(last_hdr);
            end
            count_grants();
            last_hdr = reader_turn ? frame_reader.hdr : frame_writer.hdr;
            next_cycle();
            // The granted requester moves on to its next line
            if (reader_turn)
            begin
                frame_reader.hdr = rand_hdr();
            end
            else
            begin
                frame_writer.hdr = rand_hdr();
            end
            reader_turn = !reader_turn;
        end
        frame_reader = '0;
        frame_writer = '0;
        wait_grant(3'b100, "status");
        count_grants();
        last_hdr = status_req.hdr;
        next_cycle();
        status_req = '0;
        @(negedge clk);
        check_tx(last_hdr);
        next_cycle();
    endtask

    task automatic almostfull_throttle();
        logic granted;
        frame_reader   = {1'b1, rand_hdr()};
        frame_writer   = {1'b1, rand_hdr()};
        tx0_almostfull = 1'b1;
        // Slack grants come first and then the channel must stay quiet
        for (int i = 0; i < ISSUE_SLACK + 10; i++)
        begin
            @(negedge clk);
            granted = |grant_bits();
            check_eq(64'(granted), 64'(i < ISSUE_SLACK), "grant under almostfull");
            check_eq(64'(rd_grant.can_issue), 64'(i < ISSUE_SLACK),
                     "can_issue under almostfull");
            count_grants();
            next_cycle();
        end
        tx0_almostfull = 1'b0;
        wait_grant(3'b011, "frame after almostfull fell");
        check_eq(64'(rd_grant.can_issue), 64'd1, "can_issue after almostfull fell");
        count_grants();
        next_cycle();
        frame_reader = '0;
        frame_writer = '0;
        next_cycle();
    endtask

    task automatic counter_readback();
        logic [31:0] data;
        logic        err;
        apb_read(hc_pkg::HC_REG_CTRL, data, err);
        check_eq(64'(data), 64'd1, "CTRL enable bit");
        apb_read(hc_pkg::HC_REG_CNT_READER, data, err);
        check_eq(64'(data), 64'(n_reader), "reader grant count");
        apb_read(hc_pkg::HC_REG_CNT_WRITER, data, err);
        check_eq(64'(data), 64'(n_writer), "writer grant count");
        apb_read(hc_pkg::HC_REG_CNT_STATUS, data, err);
        check_eq(64'(data), 64'(n_status), "status grant count");
        // Clearing one counter leaves the others alone
        apb_write(hc_pkg::HC_REG_CNT_READER, 32'hFFFF_FFFF, err);
        apb_read(hc_pkg::HC_REG_CNT_READER, data, err);
        check_eq(64'(data), 64'd0, "reader count after clear");
        apb_read(hc_pkg::HC_REG_CNT_WRITER, data, err);
        check_eq(64'(data), 64'(n_writer), "writer count after reader clear");
        apb_write(8'h10, 32'h0, err);
        check_eq(64'(err), 64'd1, "pslverr on unmapped write");
        apb_read(8'h10, data, err);
        check_eq(64'(err), 64'd1, "pslverr on unmapped read");
    endtask

    initial
    begin
        void'($urandom(75314));
        clk            = 1'b0;
        reset_n        = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        frame_reader   = '0;
        frame_writer   = '0;
        status_req     = '0;
        tx0_almostfull = 1'b0;
        n_reader       = 0;
        n_writer       = 0;
        n_status       = 0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;
        no_grant_while_disabled();
        single_reader_grant();
        reader_writer_alternation();
        almostfull_throttle();
        counter_readback();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/hc_pkg.sv
hdl/hc_csr_regs.sv
hdl/hc_issue_ctrl.sv
hdl/hc_read_arbiter.sv
hdl/hc_read_top.sv
bench/hc_read_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the read arbiter testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module hc_read_tb --Mdir "$BUILD_DIR" -o hc_read_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/hc_read_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
